/* Makefile */
TOP := bpu_tb

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* files.f */
hw/bpu_pkg.sv
hw/bht.sv
hw/btb.sv
hw/branch_predictor.sv
hw/resolve_port.sv
hw/bpu_top.sv
testbench/bpu_tb.sv

/* hw/bht.sv */
`timescale 1ns/1ps

module bht import bpu_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  virt_t          vaddr,
	input  bht_update_t    update,
	output counter_t [1:0] predict
);

	// bank 0 holds slot 0, bank 1 holds slot 1
	counter_t counters [2][BPU_ENTRIES];

	bpu_idx_t rd_idx;
	bpu_idx_t wr_idx;
	logic     wr_bank;
	counter_t next_counter;

	assign rd_idx  = bpu_index(vaddr);
	assign wr_idx  = bpu_index(update.pc);
	assign wr_bank = update.pc[2];

	// step the counter carried with the prediction, saturating at both ends
	always_comb begin
		next_counter = update.counter;
		if (update.taken && update.counter != 2'b11) begin
			next_counter = update.counter + 2'd1;
		end else if (!update.taken && update.counter != 2'b00) begin
			next_counter = update.counter - 2'd1;
		end
	end

	// weakly not taken after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int bank = 0; bank < 2; bank++) begin
				for (int i = 0; i < BPU_ENTRIES; i++) begin
					counters[bank][i] <= 2'b01;
				end
			end
		end else if (update.valid) begin
			counters[wr_bank][wr_idx] <= next_counter;
		end
	end

	// registered read of both banks
	always_ff @(posedge clk) begin
		predict[0] <= counters[0][rd_idx];
		predict[1] <= counters[1][rd_idx];
	end

endmodule

/* hw/bpu_pkg.sv */
package bpu_pkg;

	// address and cache geometry
	localparam int VADDR_WIDTH       = 32;
	localparam int ICACHE_LINE_WIDTH = 256;
	localparam int ICACHE_ADDR_WIDTH = $clog2(ICACHE_LINE_WIDTH / 8);

	// table index starts above the 8-byte pair offset
	localparam int BPU_ENTRIES   = 64;
	localparam int BPU_IDX_WIDTH = $clog2(BPU_ENTRIES);
	localparam int BPU_IDX_LSB   = 3;
	localparam int BTB_TAG_WIDTH = 23;

	typedef logic [VADDR_WIDTH-1:0]   virt_t;
	typedef logic [1:0]               cf_t;
	// upper bit set means taken
	typedef logic [1:0]               counter_t;
	typedef logic [BPU_IDX_WIDTH-1:0] bpu_idx_t;
	typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;

	// control-flow kinds
	localparam cf_t CF_NONE     = 2'd0;
	localparam cf_t CF_BRANCH   = 2'd1;
	localparam cf_t CF_JUMP     = 2'd2;
	localparam cf_t CF_INDIRECT = 2'd3;

	typedef struct packed {
		logic     valid;
		virt_t    pc;
		virt_t    target;
		cf_t      cf;
		logic     taken;
		counter_t counter;
	} branch_resolved_t;

	typedef struct packed {
		logic  valid;
		virt_t pc;
	} presolved_branch_t;

	typedef struct packed {
		logic     valid;
		logic     taken;
		logic     wait_delayslot;
		cf_t      cf;
		counter_t counter;
		virt_t    target;
	} branch_predict_t;

	typedef struct packed {
		logic     valid;
		virt_t    pc;
		logic     taken;
		counter_t counter;
	} bht_update_t;

	typedef struct packed {
		logic  valid;
		virt_t pc;
		virt_t target;
		cf_t   cf;
	} btb_update_t;

	typedef struct packed {
		cf_t   cf;
		virt_t target;
	} btb_predict_t;

	function automatic bpu_idx_t bpu_index(input virt_t pc);
		return pc[BPU_IDX_LSB +: BPU_IDX_WIDTH];
	endfunction

	function automatic btb_tag_t btb_tag(input virt_t pc);
		return pc[VADDR_WIDTH-1 -: BTB_TAG_WIDTH];
	endfunction

endpackage

/* hw/bpu_top.sv */
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  logic              skip,
	input  logic              resolve_req,
	input  virt_t             pc_cur,
	input  virt_t             pc_prev,
	input  branch_resolved_t  resolved_in,
	input  presolved_branch_t presolved_branch,
	output logic              resolve_ack,
	output branch_predict_t   prediction,
	output logic [1:0]        prediction_sel
);

	// single-cycle update from the back end
	branch_resolved_t resolved_branch;

	resolve_port resolve_port0 (
		.clk,
		.rst,
		.resolve_req,
		.resolved_in,
		.resolve_ack,
		.resolved_branch
	);

	branch_predictor branch_predictor0 (
		.clk,
		.rst,
		.stall,
		.flush,
		.skip,
		.pc_cur,
		.pc_prev,
		.resolved_branch,
		.presolved_branch,
		.prediction,
		.prediction_sel
	);

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import bpu_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  logic              skip,
	// pair being fetched now, and last cycle's
	input  virt_t             pc_cur,
	input  virt_t             pc_prev,
	input  branch_resolved_t  resolved_branch,
	input  presolved_branch_t presolved_branch,
	output branch_predict_t   prediction,
	output logic [1:0]        prediction_sel
);

	bht_update_t bht_update;
	btb_update_t btb_update;

	counter_t     [1:0] bht_predict, bht_predict_delay, bht_source;
	btb_predict_t [1:0] btb_predict, btb_predict_delay, btb_source;

	logic         pipe_stall;
	logic         pipe_flush;
	logic         slot;
	btb_predict_t btb_selected;
	counter_t     bht_selected;

	// counters only learn from conditional branches
	always_comb begin
		bht_update.valid   = resolved_branch.valid && resolved_branch.cf == CF_BRANCH;
		bht_update.pc      = resolved_branch.pc;
		bht_update.taken   = resolved_branch.taken;
		bht_update.counter = resolved_branch.counter;

		btb_update.valid  = resolved_branch.valid;
		btb_update.pc     = resolved_branch.pc;
		btb_update.target = resolved_branch.target;
		btb_update.cf     = resolved_branch.cf;
	end

	// keep the table outputs of lookups issued while not stalled
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			bht_predict_delay <= '0;
			btb_predict_delay <= '0;
		end else if (!pipe_stall) begin
			bht_predict_delay <= bht_predict;
			btb_predict_delay <= btb_predict;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_stall <= 1'b0;
			pipe_flush <= 1'b0;
		end else begin
			pipe_stall <= stall;
			pipe_flush <= flush;
		end
	end

	always_comb begin
		if (stall || pipe_flush) begin
			bht_source = bht_predict_delay;
			btb_source = btb_predict_delay;
		end else begin
			bht_source = bht_predict;
			btb_source = btb_predict;
		end

		// an unaligned pc has only slot 1 left in the pair
		if (pc_prev[2]) begin
			slot = 1'b1;
		end else begin
			slot = btb_source[0].cf == CF_NONE;
		end

		prediction_sel       = '0;
		prediction_sel[slot] = 1'b1;
		btb_selected         = btb_source[slot];
		bht_selected         = bht_source[slot];

		prediction.valid   = btb_selected.cf != CF_NONE && !skip && !pipe_flush;
		prediction.taken   = btb_selected.cf == CF_BRANCH ? bht_selected[1] : 1'b1;
		prediction.cf      = btb_selected.cf;
		prediction.counter = bht_selected;
		prediction.target  = btb_selected.target;
		// the delay slot after slot 1 of the last pair sits in the next line
		prediction.wait_delayslot = slot && (&pc_prev[ICACHE_ADDR_WIDTH-1:BPU_IDX_LSB]);
	end

	bht bht0 (
		.clk,
		.rst,
		.vaddr   (pc_cur),
		.update  (bht_update),
		.predict (bht_predict)
	);

	btb btb0 (
		.clk,
		.rst,
		.vaddr            (pc_cur),
		.update           (btb_update),
		.presolved_branch (presolved_branch),
		.predict          (btb_predict)
	);

endmodule

/* hw/btb.sv */
`timescale 1ns/1ps

module btb import bpu_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  virt_t              vaddr,
	input  btb_update_t        update,
	input  presolved_branch_t  presolved_branch,
	output btb_predict_t [1:0] predict
);

	logic [1:0][BPU_ENTRIES-1:0] entry_valid;
	btb_tag_t tags    [2][BPU_ENTRIES];
	virt_t    targets [2][BPU_ENTRIES];
	cf_t      kinds   [2][BPU_ENTRIES];

	bpu_idx_t rd_idx;
	btb_tag_t rd_tag;
	bpu_idx_t upd_idx;
	logic     upd_bank;
	bpu_idx_t inv_idx;
	logic     inv_bank;
	logic     inv_hit;

	btb_predict_t [1:0] lookup;

	assign rd_idx   = bpu_index(vaddr);
	assign rd_tag   = btb_tag(vaddr);
	assign upd_idx  = bpu_index(update.pc);
	assign upd_bank = update.pc[2];
	assign inv_idx  = bpu_index(presolved_branch.pc);
	assign inv_bank = presolved_branch.pc[2];

	// only drop the entry if it really belongs to the presolved pc
	assign inv_hit = presolved_branch.valid
		&& tags[inv_bank][inv_idx] == btb_tag(presolved_branch.pc);

	always_comb begin
		for (int bank = 0; bank < 2; bank++) begin
			lookup[bank].target = targets[bank][rd_idx];
			if (entry_valid[bank][rd_idx] && tags[bank][rd_idx] == rd_tag) begin
				lookup[bank].cf = kinds[bank][rd_idx];
			end else begin
				lookup[bank].cf = CF_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		predict <= lookup;
	end

	// a resolved branch on the same entry wins over invalidation
	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= '0;
		end else begin
			if (inv_hit) begin
				entry_valid[inv_bank][inv_idx] <= 1'b0;
			end
			if (update.valid) begin
				entry_valid[upd_bank][upd_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (update.valid) begin
			tags[upd_bank][upd_idx]    <= btb_tag(update.pc);
			targets[upd_bank][upd_idx] <= update.target;
			kinds[upd_bank][upd_idx]   <= update.cf;
		end
	end

endmodule

/* hw/resolve_port.sv */
`timescale 1ns/1ps

module resolve_port import bpu_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             resolve_req,
	input  branch_resolved_t resolved_in,
	output logic             resolve_ack,
	output branch_resolved_t resolved_branch
);

	typedef enum logic [1:0] {
		IDLE,
		PULSE,
		WAIT_DROP
	} resolve_port_state_t;

	resolve_port_state_t state;
	branch_resolved_t    payload;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:      if (resolve_req) state <= PULSE;
				PULSE:     state <= WAIT_DROP;
				// hold ack until the back end lets go of req
				WAIT_DROP: if (!resolve_req) state <= IDLE;
				default:   state <= IDLE;
			endcase
		end
	end

	// payload is stable while req is high
	always_ff @(posedge clk) begin
		if (state == IDLE && resolve_req) begin
			payload <= resolved_in;
		end
	end

	always_comb begin
		resolved_branch       = payload;
		resolved_branch.valid = state == PULSE;
	end

	assign resolve_ack = state == WAIT_DROP;

endmodule

/* testbench/bpu_tb.sv */
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

	localparam int ACK_TIMEOUT = 20;

	logic              clk;
	logic              rst;
	logic              stall;
	logic              flush;
	logic              skip;
	logic              resolve_req;
	virt_t             pc_cur;
	virt_t             pc_prev;
	branch_resolved_t  resolved_in;
	presolved_branch_t presolved_branch;
	logic              resolve_ack;
	branch_predict_t   prediction;
	logic [1:0]        prediction_sel;

	int          errors;
	logic [15:0] lfsr_state;

	// table model with bank 0 as slot 0
	counter_t m_ctr    [2][BPU_ENTRIES];
	logic     m_valid  [2][BPU_ENTRIES];
	btb_tag_t m_tag    [2][BPU_ENTRIES];
	virt_t    m_target [2][BPU_ENTRIES];
	cf_t      m_kind   [2][BPU_ENTRIES];

	bpu_top dut0 (
		.clk,
		.rst,
		.stall,
		.flush,
		.skip,
		.resolve_req,
		.pc_cur,
		.pc_prev,
		.resolved_in,
		.presolved_branch,
		.resolve_ack,
		.prediction,
		.prediction_sel
	);

	always #5 clk = ~clk;

	// galois lfsr stepped once per bit
	function automatic logic next_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 16'hb400;
		end
		return lsb;
	endfunction

	function automatic virt_t rand_bits(input int n);
		virt_t word;
		word = '0;
		for (int i = 0; i < n; i++) begin
			word = {word[30:0], next_bit()};
		end
		return word;
	endfunction

	function automatic counter_t saturate_step(input counter_t c, input logic taken);
		if (taken) begin
			return (c == 2'b11) ? c : c + 2'd1;
		end
		return (c == 2'b00) ? c : c - 2'd1;
	endfunction

	// outputs are sampled 1 ns after the rising edge and before the next drive
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic send_resolve(input virt_t pc, input virt_t target, input cf_t cf,
			input logic taken, input counter_t ctr);
		int       cycles;
		logic     bank;
		bpu_idx_t idx;
		bank = pc[2];
		idx  = pc[8:3];
		resolved_in.valid   = 1'b1;
		resolved_in.pc      = pc;
		resolved_in.target  = target;
		resolved_in.cf      = cf;
		resolved_in.taken   = taken;
		resolved_in.counter = ctr;
		resolve_req = 1'b1;
		cycles = 0;
		while (resolve_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (resolve_ack !== 1'b1) begin
			$display("timeout: resolve_ack did not rise for pc %h", pc);
			errors++;
		end else begin
			check(32'(cycles), 32'd2, "req to ack cycles");
		end
		resolve_req = 1'b0;
		resolved_in.valid = 1'b0;
		cycles = 0;
		while (resolve_ack !== 1'b0 && cycles < ACK_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (resolve_ack !== 1'b0) begin
			$display("timeout: resolve_ack did not drop after req was lowered");
			errors++;
		end
		if (cf == CF_BRANCH) begin
			m_ctr[bank][idx] = saturate_step(ctr, taken);
		end
		m_valid[bank][idx]  = 1'b1;
		m_tag[bank][idx]    = pc[31:9];
		m_target[bank][idx] = target;
		m_kind[bank][idx]   = cf;
	endtask

	task automatic presolve(input virt_t pc);
		presolved_branch.valid = 1'b1;
		presolved_branch.pc    = pc;
		next_cycle();
		presolved_branch.valid = 1'b0;
		if (m_valid[pc[2]][pc[8:3]] && m_tag[pc[2]][pc[8:3]] == pc[31:9]) begin
			m_valid[pc[2]][pc[8:3]] = 1'b0;
		end
	endtask

	// expected output for a lookup with pc_prev equal to pc
	task automatic model_lookup(input virt_t pc, output branch_predict_t exp_pred,
			output logic [1:0] exp_sel);
		cf_t      cf [2];
		bpu_idx_t idx;
		logic     slot;
		idx = pc[8:3];
		for (int b = 0; b < 2; b++) begin
			cf[b] = (m_valid[b][idx] && m_tag[b][idx] == pc[31:9]) ? m_kind[b][idx] : CF_NONE;
		end
		slot = pc[2] ? 1'b1 : (cf[0] == CF_NONE);
		exp_sel = 2'b01 << slot;
		exp_pred.cf      = cf[slot];
		exp_pred.valid   = cf[slot] != CF_NONE && !skip;
		exp_pred.taken   = cf[slot] == CF_BRANCH ? m_ctr[slot][idx][1] : 1'b1;
		exp_pred.counter = m_ctr[slot][idx];
		exp_pred.target  = m_target[slot][idx];
		exp_pred.wait_delayslot = slot && pc[4:3] == 2'b11;
	endtask

	task automatic lookup_compare(input virt_t pc);
		branch_predict_t exp_pred;
		logic [1:0]      exp_sel;
		pc_cur  = pc;
		pc_prev = pc;
		next_cycle();
		model_lookup(pc, exp_pred, exp_sel);
		check(32'(prediction.valid), 32'(exp_pred.valid), "prediction.valid");
		check(32'(prediction.cf), 32'(exp_pred.cf), "prediction.cf");
		check(32'(prediction.taken), 32'(exp_pred.taken), "prediction.taken");
		check(32'(prediction.counter), 32'(exp_pred.counter), "prediction.counter");
		check(32'(prediction.wait_delayslot), 32'(exp_pred.wait_delayslot), "wait_delayslot");
		check(32'(prediction_sel), 32'(exp_sel), "prediction_sel");
		if (exp_pred.cf != CF_NONE) begin
			check(prediction.target, exp_pred.target, "prediction.target");
		end
	endtask

	task automatic reset_state();
		check(32'(resolve_ack), 32'd0, "resolve_ack after reset");
		check(32'(prediction.valid), 32'd0, "valid after reset");
		lookup_compare(rand_bits(29) << 3);
		check(32'(prediction.cf), 32'(CF_NONE), "cf of an untrained pc");
		check(32'(prediction_sel), 32'd2, "slot with empty slot 0");
	endtask

	task automatic jump_training();
		virt_t pc;
		pc = rand_bits(30) << 2;
		send_resolve(pc, rand_bits(30) << 2, CF_JUMP, 1'b1, 2'b00);
		lookup_compare(pc);
		check(32'(prediction.valid), 32'd1, "valid after jump training");
		pc = rand_bits(30) << 2;
		send_resolve(pc, rand_bits(30) << 2, CF_INDIRECT, 1'b1, 2'b00);
		lookup_compare(pc);
		check(32'(prediction.taken), 32'd1, "taken after indirect training");
		// flipping bit 31 changes only the tag
		lookup_compare(pc ^ 32'h8000_0000);
		check(32'(prediction.valid), 32'd0, "valid on tag mismatch");
	endtask

	task automatic counter_training();
		virt_t    pc;
		counter_t ctr;
		logic     taken;
		pc = rand_bits(30) << 2;
		for (int i = 0; i < 8; i++) begin
			ctr   = counter_t'(rand_bits(2));
			taken = rand_bits(1) != 0;
			send_resolve(pc, rand_bits(30) << 2, CF_BRANCH, taken, ctr);
			lookup_compare(pc);
		end
		// both saturation ends
		send_resolve(pc, rand_bits(30) << 2, CF_BRANCH, 1'b1, 2'b11);
		lookup_compare(pc);
		send_resolve(pc, rand_bits(30) << 2, CF_BRANCH, 1'b0, 2'b00);
		lookup_compare(pc);
	endtask

	task automatic slot_selection();
		virt_t base;
		// last pair of the line
		base = (rand_bits(27) << 5) | 32'h18;
		send_resolve(base, rand_bits(30) << 2, CF_JUMP, 1'b1, 2'b00);
		send_resolve(base | 32'h4, rand_bits(30) << 2, CF_BRANCH, 1'b1, 2'b10);
		lookup_compare(base);
		check(32'(prediction_sel), 32'd1, "slot 0 chosen");
		check(32'(prediction.wait_delayslot), 32'd0, "no delay slot wait on slot 0");
		lookup_compare(base | 32'h4);
		check(32'(prediction_sel), 32'd2, "slot 1 chosen for unaligned pc");
		check(32'(prediction.wait_delayslot), 32'd1, "delay slot wait at line end");
		base = (rand_bits(27) << 5) | 32'h8;
		send_resolve(base | 32'h4, rand_bits(30) << 2, CF_JUMP, 1'b1, 2'b00);
		lookup_compare(base | 32'h4);
		check(32'(prediction.wait_delayslot), 32'd0, "no delay slot wait mid line");
		lookup_compare(base);
	endtask

	task automatic invalidate_skip_flush();
		virt_t pc;
		pc = rand_bits(30) << 2;
		send_resolve(pc, rand_bits(30) << 2, CF_JUMP, 1'b1, 2'b00);
		lookup_compare(pc);
		presolve(pc);
		lookup_compare(pc);
		check(32'(prediction.valid), 32'd0, "valid after invalidation");
		send_resolve(pc, rand_bits(30) << 2, CF_JUMP, 1'b1, 2'b00);
		skip = 1'b1;
		lookup_compare(pc);
		check(32'(prediction.valid), 32'd0, "valid with skip");
		skip = 1'b0;
		lookup_compare(pc);
		flush = 1'b1;
		next_cycle();
		check(32'(prediction.valid), 32'd0, "valid in the cycle after flush");
		flush = 1'b0;
		next_cycle();
		check(32'(prediction.valid), 32'd1, "valid once flush is over");
	endtask

	task automatic stall_hold();
		virt_t first;
		virt_t second;
		virt_t t_first;
		virt_t t_second;
		first    = rand_bits(29) << 3;
		second   = first ^ 32'h8;
		t_first  = rand_bits(30) << 2;
		t_second = rand_bits(30) << 2;
		send_resolve(first, t_first, CF_JUMP, 1'b1, 2'b00);
		send_resolve(second, t_second, CF_JUMP, 1'b1, 2'b00);
		lookup_compare(first);
		stall  = 1'b1;
		pc_cur = second;
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			check(32'(prediction.valid), 32'd1, "valid during stall");
			check(prediction.target, t_first, "target held during stall");
			pc_cur = rand_bits(29) << 3;
		end
		stall = 1'b0;
		lookup_compare(second);
		check(prediction.target, t_second, "target after stall");
	endtask

	initial begin
		clk              = 1'b0;
		rst              = 1'b1;
		stall            = 1'b0;
		flush            = 1'b0;
		skip             = 1'b0;
		resolve_req      = 1'b0;
		pc_cur           = '0;
		pc_prev          = '0;
		resolved_in      = '0;
		presolved_branch = '0;
		errors           = 0;
		lfsr_state       = 16'd54221;
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < BPU_ENTRIES; i++) begin
				m_ctr[b][i]   = 2'b01;
				m_valid[b][i] = 1'b0;
			end
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_state();
		jump_training();
		counter_training();
		slot_selection();
		invalidate_skip_flush();
		stall_hold();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
